// ==== aluPkg.sv ====
/* opcodes keep the phase-one CPU encoding; INCPC takes the unused value 01100
   unit index constants fix the bit order of every per-unit vector */
`default_nettype none

package aluPkg;

	// operand width of every unit
	localparam int dataWidth = 32;

	// peer execution units sharing the result bus
	localparam int unitCount = 3;

	// bit positions in start, busy, done and grant
	localparam int unitCore = 0;
	localparam int unitMul = 1;
	localparam int unitDiv = 2;

	// 5-bit operation codes
	typedef enum logic [4:0] {
		opAdd   = 5'b00011,
		opSub   = 5'b00100,
		opShr   = 5'b00101,
		opShra  = 5'b00110,
		opShl   = 5'b00111,
		opRor   = 5'b01000,
		opRol   = 5'b01001,
		opAnd   = 5'b01010,
		opOr    = 5'b01011,
		// program counter step, B plus one
		opIncPc = 5'b01100,
		opMul   = 5'b01111,
		opDiv   = 5'b10000,
		opNeg   = 5'b10001,
		opNot   = 5'b10010
	} aluOp_e;

endpackage

`default_nettype wire

// ==== opDispatch.sv ====
/* one command in flight on the four-phase channel; a command for a busy unit
   waits with cmdAck low until that unit has been released */
`timescale 1ns/10ps
`default_nettype none

module opDispatch #(
	parameter int tagWidth = 4
) (
	input  logic                           clk,
	input  logic                           rstN,
	input  logic                           cmdReq,
	input  aluPkg::aluOp_e                 cmdOp,
	input  logic [aluPkg::dataWidth-1:0]   cmdA,
	input  logic [aluPkg::dataWidth-1:0]   cmdB,
	input  logic [tagWidth-1:0]            cmdTag,
	input  logic [aluPkg::unitCount-1:0]   busy,
	output logic                           cmdAck,
	output logic [aluPkg::unitCount-1:0]   start,
	output aluPkg::aluOp_e                 op,
	output logic [aluPkg::dataWidth-1:0]   a,
	output logic [aluPkg::dataWidth-1:0]   b,
	output logic [tagWidth-1:0]            tag
);
	import aluPkg::*;

	typedef enum logic {
		dispIdle,
		dispAcked
	} dispState_e;

	dispState_e state;
	logic [unitCount-1:0] targetMask;
	logic accept;

	// opcode to unit, everything but MUL and DIV runs in the core
	always_comb begin
		targetMask = '0;
		case (cmdOp)
			opMul: targetMask[unitMul] = 1'b1;
			opDiv: targetMask[unitDiv] = 1'b1;
			default: targetMask[unitCore] = 1'b1;
		endcase
	end

	// request seen and the target unit is free
	assign accept = (state == dispIdle) && cmdReq && ((busy & targetMask) == '0);

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			state <= dispIdle;
			cmdAck <= 1'b0;
			start <= '0;
		end else begin
			// start is a single-cycle pulse
			start <= '0;
			case (state)
				dispIdle: begin
					if (accept) begin
						cmdAck <= 1'b1;
						start <= targetMask;
						state <= dispAcked;
					end
				end
				dispAcked: begin
					// wait for the return-to-zero half of the handshake
					if (!cmdReq) begin
						cmdAck <= 1'b0;
						state <= dispIdle;
					end
				end
				default: state <= dispIdle;
			endcase
		end
	end

	// operands broadcast to all units, captured with the start pulse
	always_ff @(posedge clk) begin
		if (accept) begin
			op <= cmdOp;
			a <= cmdA;
			b <= cmdB;
			tag <= cmdTag;
		end
	end

	// a unit is only started once its previous result has been accepted
	assert property (@(posedge clk) disable iff (!rstN) (start & busy) == '0)
		else $error("start issued to a busy unit");

endmodule

`default_nettype wire

// ==== aluCore.sv ====
/* single-cycle unit; MUL and DIV are never routed here and fall to the default
   HI is always zero, shift amounts use all of B, rotates use B modulo 32 */
`timescale 1ns/10ps
`default_nettype none

module aluCore #(
	parameter int tagWidth = 4
) (
	input  logic                           clk,
	input  logic                           rstN,
	input  logic                           start,
	input  aluPkg::aluOp_e                 op,
	input  logic [aluPkg::dataWidth-1:0]   a,
	input  logic [aluPkg::dataWidth-1:0]   b,
	input  logic [tagWidth-1:0]            tagIn,
	input  logic                           grant,
	output logic                           busy,
	output logic                           done,
	output logic [aluPkg::dataWidth-1:0]   resHigh,
	output logic [aluPkg::dataWidth-1:0]   resLow,
	output logic [tagWidth-1:0]            resTag
);
	import aluPkg::*;

	// bits of B that select a shift position
	localparam int amtWidth = $clog2(dataWidth);

	logic holding;
	logic bigShift;
	logic [amtWidth-1:0] amount;
	logic [2*dataWidth-1:0] rorWide;
	logic [2*dataWidth-1:0] rolWide;
	logic [dataWidth-1:0] sraOut;
	logic [dataWidth-1:0] nextLow;

	// any upper bit of B set means the shift runs off the word
	assign bigShift = |b[dataWidth-1:amtWidth];
	assign amount = b[amtWidth-1:0];

	// rotate through a doubled copy of A
	assign rorWide = {a, a} >> amount;
	assign rolWide = {a, a} << amount;

	// sign-filling shift for amounts below 32
	assign sraOut = $signed(a) >>> amount;

	always_comb begin
		case (op)
			opAdd: nextLow = a + b;
			opSub: nextLow = a - b;
			opAnd: nextLow = a & b;
			opOr: nextLow = a | b;
			opShr: nextLow = bigShift ? '0 : a >> amount;
			// oversized arithmetic shift leaves only sign bits
			opShra: nextLow = bigShift ? {dataWidth{a[dataWidth-1]}} : sraOut;
			opShl: nextLow = bigShift ? '0 : a << amount;
			opRor: nextLow = rorWide[dataWidth-1:0];
			opRol: nextLow = rolWide[2*dataWidth-1:dataWidth];
			// two's complement of B
			opNeg: nextLow = -b;
			opNot: nextLow = ~b;
			opIncPc: nextLow = b + 1'b1;
			// debug pattern for an opcode that does not decode
			default: nextLow = 32'hAAAA_AAAA;
		endcase
	end

	// result is ready the cycle after start and held until grant
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			holding <= 1'b0;
		end else if (start) begin
			holding <= 1'b1;
		end else if (grant) begin
			holding <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (start) begin
			resLow <= nextLow;
			resTag <= tagIn;
		end
	end

	assign busy = holding;
	assign done = holding;
	// hi word only carries MUL and DIV results
	assign resHigh = '0;

endmodule

`default_nettype wire

// ==== boothMultiplier.sv ====
/* signed 32x32 multiply, two multiplier bits per cycle; done 16 cycles after start
   operands are only sampled on start, the product is held until grant */
`timescale 1ns/10ps
`default_nettype none

module boothMultiplier #(
	parameter int tagWidth = 4
) (
	input  logic                           clk,
	input  logic                           rstN,
	input  logic                           start,
	input  logic [aluPkg::dataWidth-1:0]   a,
	input  logic [aluPkg::dataWidth-1:0]   b,
	input  logic [tagWidth-1:0]            tagIn,
	input  logic                           grant,
	output logic                           busy,
	output logic                           done,
	output logic [aluPkg::dataWidth-1:0]   resHigh,
	output logic [aluPkg::dataWidth-1:0]   resLow,
	output logic [tagWidth-1:0]            resTag
);
	import aluPkg::*;

	localparam int stepTotal = dataWidth / 2;
	localparam int stepWidth = $clog2(stepTotal);

	logic running;
	logic [stepWidth-1:0] stepCount;
	logic [2*dataWidth-1:0] acc;
	logic [2*dataWidth-1:0] mcand;
	logic [2*dataWidth-1:0] aWide;
	// multiplier with the implicit zero below bit 0
	logic [dataWidth:0] mplier;

	// bit-pair recoding, group to 0, +-1 or +-2 times the multiplicand
	function automatic logic [2*dataWidth-1:0] boothTerm(input logic [2:0] grp,
		input logic [2*dataWidth-1:0] m);
		case (grp)
			3'b001, 3'b010: boothTerm = m;
			3'b011: boothTerm = m << 1;
			3'b100: boothTerm = -(m << 1);
			3'b101, 3'b110: boothTerm = -m;
			default: boothTerm = '0;
		endcase
	endfunction

	assign aWide = {{dataWidth{a[dataWidth-1]}}, a};

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			busy <= 1'b0;
			done <= 1'b0;
			running <= 1'b0;
			stepCount <= '0;
		end else begin
			if (start) begin
				// group 0 is folded into the load
				busy <= 1'b1;
				running <= 1'b1;
				stepCount <= stepWidth'(1);
			end else if (running) begin
				stepCount <= stepCount + 1'b1;
				if (stepCount == stepWidth'(stepTotal - 1)) begin
					running <= 1'b0;
					done <= 1'b1;
				end
			end
			if (grant) begin
				busy <= 1'b0;
				done <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (start) begin
			acc <= boothTerm({b[1:0], 1'b0}, aWide);
			mcand <= aWide << 2;
			// {b, 0} shifted right two places, sign kept
			mplier <= {b[dataWidth-1], b[dataWidth-1], b[dataWidth-1:1]};
			resTag <= tagIn;
		end else if (running) begin
			acc <= acc + boothTerm(mplier[2:0], mcand);
			mcand <= mcand << 2;
			mplier <= {mplier[dataWidth], mplier[dataWidth], mplier[dataWidth:2]};
		end
	end

	assign resHigh = acc[2*dataWidth-1:dataWidth];
	assign resLow = acc[dataWidth-1:0];

endmodule

`default_nettype wire

// ==== nonRestoringDivider.sv ====
/* unsigned divide, quotient on LO and remainder on HI; done 33 cycles after start
   divide by zero returns an all-ones quotient and the dividend as remainder */
`timescale 1ns/10ps
`default_nettype none

module nonRestoringDivider #(
	parameter int tagWidth = 4
) (
	input  logic                           clk,
	input  logic                           rstN,
	input  logic                           start,
	input  logic [aluPkg::dataWidth-1:0]   a,
	input  logic [aluPkg::dataWidth-1:0]   b,
	input  logic [tagWidth-1:0]            tagIn,
	input  logic                           grant,
	output logic                           busy,
	output logic                           done,
	output logic [aluPkg::dataWidth-1:0]   resHigh,
	output logic [aluPkg::dataWidth-1:0]   resLow,
	output logic [tagWidth-1:0]            resTag
);
	import aluPkg::*;

	localparam int phaseWidth = $clog2(dataWidth) + 1;

	logic running;
	logic lastPhase;
	logic [phaseWidth-1:0] phase;
	// signed partial remainder, one bit wider than the divisor
	logic [dataWidth:0] rem;
	logic [dataWidth:0] divisor;
	logic [dataWidth-1:0] quo;
	logic [dataWidth:0] remIn;
	logic [dataWidth:0] dIn;
	logic [dataWidth-1:0] quoIn;
	logic [dataWidth:0] shRem;
	logic [dataWidth:0] stepRem;

	// first iteration runs on the load, straight from the operands
	always_comb begin
		remIn = start ? '0 : rem;
		quoIn = start ? a : quo;
		dIn = start ? {1'b0, b} : divisor;
		shRem = {remIn[dataWidth-1:0], quoIn[dataWidth-1]};
		// sign taken before the shift decides add or subtract
		stepRem = remIn[dataWidth] ? shRem + dIn : shRem - dIn;
	end

	// 32 iterations are complete once phase reaches dataWidth
	assign lastPhase = (phase == phaseWidth'(dataWidth));

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			busy <= 1'b0;
			done <= 1'b0;
			running <= 1'b0;
			phase <= '0;
		end else begin
			if (start) begin
				busy <= 1'b1;
				running <= 1'b1;
				phase <= phaseWidth'(1);
			end else if (running) begin
				if (lastPhase) begin
					running <= 1'b0;
					done <= 1'b1;
				end else begin
					phase <= phase + 1'b1;
				end
			end
			if (grant) begin
				busy <= 1'b0;
				done <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (start || (running && !lastPhase)) begin
			rem <= stepRem;
			quo <= {quoIn[dataWidth-2:0], ~stepRem[dataWidth]};
			divisor <= dIn;
		end else if (running && rem[dataWidth]) begin
			// correction step, restore a negative remainder
			rem <= rem + divisor;
		end
		if (start) begin
			resTag <= tagIn;
		end
	end

	assign resHigh = rem[dataWidth-1:0];
	assign resLow = quo;

endmodule

`default_nettype wire

// ==== resultArbiter.sv ====
/* one result on the four-phase channel at a time; the next pick waits for resAck low
   unit data must stay stable while its done is high */
`timescale 1ns/10ps
`default_nettype none

module resultArbiter #(
	parameter int tagWidth = 4
) (
	input  logic                                          clk,
	input  logic                                          rstN,
	input  logic [aluPkg::unitCount-1:0]                  done,
	input  logic [aluPkg::unitCount*aluPkg::dataWidth-1:0] unitHigh,
	input  logic [aluPkg::unitCount*aluPkg::dataWidth-1:0] unitLow,
	input  logic [aluPkg::unitCount*tagWidth-1:0]         unitTag,
	input  logic                                          resAck,
	output logic [aluPkg::unitCount-1:0]                  grant,
	output logic                                          resReq,
	output logic [aluPkg::dataWidth-1:0]                  resHigh,
	output logic [aluPkg::dataWidth-1:0]                  resLow,
	output logic [tagWidth-1:0]                           resTag
);
	import aluPkg::*;

	localparam int idxWidth = $clog2(unitCount);

	typedef enum logic [1:0] {
		arbIdle,
		arbOffer,
		arbRelease
	} arbState_e;

	arbState_e state;
	logic [idxWidth-1:0] lastWinner;
	logic [idxWidth-1:0] winner;
	logic [idxWidth-1:0] pick;
	logic found;

	// round robin, search starts just after the last winner
	always_comb begin
		pick = lastWinner;
		found = 1'b0;
		for (int i = 1; i <= unitCount; i++) begin
			if (!found && done[(int'(lastWinner) + i) % unitCount]) begin
				pick = idxWidth'((int'(lastWinner) + i) % unitCount);
				found = 1'b1;
			end
		end
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			state <= arbIdle;
			resReq <= 1'b0;
			grant <= '0;
			winner <= '0;
			// core gets first turn after reset
			lastWinner <= idxWidth'(unitCount - 1);
		end else begin
			grant <= '0;
			case (state)
				arbIdle: begin
					if (found) begin
						winner <= pick;
						resReq <= 1'b1;
						state <= arbOffer;
					end
				end
				arbOffer: begin
					if (resAck) begin
						grant <= unitCount'(1) << winner;
						lastWinner <= winner;
						resReq <= 1'b0;
						state <= arbRelease;
					end
				end
				arbRelease: begin
					if (!resAck) begin
						state <= arbIdle;
					end
				end
				default: state <= arbIdle;
			endcase
		end
	end

	// capture the winner's result with the resReq rise
	always_ff @(posedge clk) begin
		if (state == arbIdle && found) begin
			resHigh <= unitHigh[pick*dataWidth +: dataWidth];
			resLow <= unitLow[pick*dataWidth +: dataWidth];
			resTag <= unitTag[pick*tagWidth +: tagWidth];
		end
	end

	assert property (@(posedge clk) disable iff (!rstN) $onehot0(grant))
		else $error("more than one grant");

	// a grant only releases a unit that is actually holding a result
	assert property (@(posedge clk) disable iff (!rstN) (grant & ~done) == '0)
		else $error("grant to a unit without done");

	assert property (@(posedge clk) disable iff (!rstN)
		resReq |=> $stable({resHigh, resLow, resTag}))
		else $error("result changed while offered");

endmodule

`default_nettype wire

// ==== aluSubsystem.sv ====
/* up to one command per unit in flight, so results may return out of order
   each result carries the tag of its command */
`timescale 1ns/10ps
`default_nettype none

module aluSubsystem #(
	parameter int tagWidth = 4
) (
	input  logic                           clk,
	input  logic                           rstN,
	input  logic                           cmdReq,
	output logic                           cmdAck,
	input  aluPkg::aluOp_e                 cmdOp,
	input  logic [aluPkg::dataWidth-1:0]   cmdA,
	input  logic [aluPkg::dataWidth-1:0]   cmdB,
	input  logic [tagWidth-1:0]            cmdTag,
	output logic                           resReq,
	input  logic                           resAck,
	output logic [tagWidth-1:0]            resTag,
	output logic [aluPkg::dataWidth-1:0]   resHigh,
	output logic [aluPkg::dataWidth-1:0]   resLow
);
	import aluPkg::*;

	// per-unit control, bit order set by the unit index constants
	logic [unitCount-1:0] start;
	logic [unitCount-1:0] busy;
	logic [unitCount-1:0] done;
	logic [unitCount-1:0] grant;

	// broadcast command fields
	aluOp_e op;
	logic [dataWidth-1:0] a;
	logic [dataWidth-1:0] b;
	logic [tagWidth-1:0] tag;

	// unit results, packed by unit index
	logic [unitCount*dataWidth-1:0] unitHigh;
	logic [unitCount*dataWidth-1:0] unitLow;
	logic [unitCount*tagWidth-1:0] unitTag;

	opDispatch #(.tagWidth(tagWidth)) dispatch (
		.clk(clk), .rstN(rstN), .cmdReq(cmdReq), .cmdOp(cmdOp), .cmdA(cmdA),
		.cmdB(cmdB), .cmdTag(cmdTag), .busy(busy), .cmdAck(cmdAck), .start(start),
		.op(op), .a(a), .b(b), .tag(tag)
	);

	aluCore #(.tagWidth(tagWidth)) core (
		.clk(clk), .rstN(rstN), .start(start[unitCore]), .op(op), .a(a), .b(b),
		.tagIn(tag), .grant(grant[unitCore]), .busy(busy[unitCore]),
		.done(done[unitCore]), .resHigh(unitHigh[unitCore*dataWidth +: dataWidth]),
		.resLow(unitLow[unitCore*dataWidth +: dataWidth]),
		.resTag(unitTag[unitCore*tagWidth +: tagWidth])
	);

	boothMultiplier #(.tagWidth(tagWidth)) mul (
		.clk(clk), .rstN(rstN), .start(start[unitMul]), .a(a), .b(b),
		.tagIn(tag), .grant(grant[unitMul]), .busy(busy[unitMul]),
		.done(done[unitMul]), .resHigh(unitHigh[unitMul*dataWidth +: dataWidth]),
		.resLow(unitLow[unitMul*dataWidth +: dataWidth]),
		.resTag(unitTag[unitMul*tagWidth +: tagWidth])
	);

	nonRestoringDivider #(.tagWidth(tagWidth)) div (
		.clk(clk), .rstN(rstN), .start(start[unitDiv]), .a(a), .b(b),
		.tagIn(tag), .grant(grant[unitDiv]), .busy(busy[unitDiv]),
		.done(done[unitDiv]), .resHigh(unitHigh[unitDiv*dataWidth +: dataWidth]),
		.resLow(unitLow[unitDiv*dataWidth +: dataWidth]),
		.resTag(unitTag[unitDiv*tagWidth +: tagWidth])
	);

	resultArbiter #(.tagWidth(tagWidth)) arbiter (
		.clk(clk), .rstN(rstN), .done(done), .unitHigh(unitHigh), .unitLow(unitLow),
		.unitTag(unitTag), .resAck(resAck), .grant(grant), .resReq(resReq),
		.resHigh(resHigh), .resLow(resLow), .resTag(resTag)
	);

endmodule

`default_nettype wire

// ==== aluChecker.sv ====
/* tags may return in any order but only once each; a tag value is assumed to
   have at most one command outstanding */
`timescale 1ns/10ps
`default_nettype none

module aluChecker #(
	parameter int tagWidth = 4
) (
	input  logic                           clk,
	input  logic                           rstN,
	input  logic                           cmdAck,
	input  aluPkg::aluOp_e                 cmdOp,
	input  logic [aluPkg::dataWidth-1:0]   cmdA,
	input  logic [aluPkg::dataWidth-1:0]   cmdB,
	input  logic [tagWidth-1:0]            cmdTag,
	input  logic                           resReq,
	input  logic                           resAck,
	input  logic [tagWidth-1:0]            resTag,
	input  logic [aluPkg::dataWidth-1:0]   resHigh,
	input  logic [aluPkg::dataWidth-1:0]   resLow,
	input  int                             testId,
	input  logic                           reportTest,
	input  logic                           reportFinal,
	output int                             errorCount
);
	import aluPkg::*;

	localparam int tagCount = 1 << tagWidth;

	// expected result per tag, filled on the command handshake
	logic [dataWidth-1:0] expHigh [tagCount];
	logic [dataWidth-1:0] expLow [tagCount];
	logic [tagCount-1:0] pending;
	logic ackSeen;
	int testCmds;
	int testResults;
	int testErrors;
	int totalCmds;
	int totalResults;
	int testsRun;

	// expected {HI, LO} from the opcode rules
	function automatic logic [63:0] modelResult(input aluOp_e op, input logic [31:0] x,
		input logic [31:0] y);
		logic [63:0] r;
		logic signed [31:0] sx;
		int n;
		r = '0;
		sx = x;
		// rotates only look at B modulo 32
		n = int'(y[4:0]);
		case (op)
			opAdd: r[31:0] = x + y;
			opSub: r[31:0] = x - y;
			opAnd: r[31:0] = x & y;
			opOr: r[31:0] = x | y;
			opShr: r[31:0] = (y > 31) ? 32'h0 : x >> y;
			opShl: r[31:0] = (y > 31) ? 32'h0 : x << y;
			opShra: begin
				if (y > 31) begin
					r[31:0] = {32{x[31]}};
				end else begin
					r[31:0] = sx >>> y;
				end
			end
			opRor: r[31:0] = (n == 0) ? x : (x >> n) | (x << (32 - n));
			opRol: r[31:0] = (n == 0) ? x : (x << n) | (x >> (32 - n));
			// full signed product from sign-extended operands
			opMul: r = {{32{x[31]}}, x} * {{32{y[31]}}, y};
			// remainder on HI, quotient on LO
			opDiv: r = (y == 0) ? {x, 32'hFFFF_FFFF} : {x % y, x / y};
			opNeg: r[31:0] = -y;
			opNot: r[31:0] = ~y;
			opIncPc: r[31:0] = y + 32'd1;
			default: r[31:0] = 32'hAAAA_AAAA;
		endcase
		return r;
	endfunction

	function automatic string testName(input int id);
		case (id)
			1: return "single-cycle opcodes";
			2: return "signed multiply";
			3: return "unsigned divide";
			4: return "mixed bursts";
			5: return "result back-pressure";
			6: return "undecoded opcodes";
			default: return "unnamed";
		endcase
	endfunction

	task automatic countError();
		errorCount++;
		testErrors++;
	endtask

	task automatic compareWord(input string name, input logic [tagWidth-1:0] t,
		input logic [31:0] expected, input logic [31:0] actual);
		if (expected !== actual) begin
			$display("ERR time=%0t signal=%s tag=%0d expected=%h actual=%h",
				$time, name, t, expected, actual);
			countError();
		end
	endtask

	always @(posedge clk) begin : watch
		logic [63:0] model;
		if (!rstN) begin
			pending = '0;
			ackSeen = 1'b0;
			errorCount = 0;
			testCmds = 0;
			testResults = 0;
			testErrors = 0;
			totalCmds = 0;
			totalResults = 0;
			testsRun = 0;
		end else begin
			// first edge with cmdAck high, fields are still held
			if (cmdAck && !ackSeen) begin
				if (pending[cmdTag]) begin
					$display("tag %0d was issued again at %0t before its result came back",
						cmdTag, $time);
					countError();
				end
				model = modelResult(cmdOp, cmdA, cmdB);
				expHigh[cmdTag] = model[63:32];
				expLow[cmdTag] = model[31:0];
				pending[cmdTag] = 1'b1;
				testCmds++;
			end
			ackSeen = cmdAck;
			// resReq drops on the edge that sees resAck, so one hit per result
			if (resReq && resAck) begin
				if (!pending[resTag]) begin
					$display("tag %0d came back at %0t with no command outstanding",
						resTag, $time);
					countError();
				end else begin
					compareWord("resHigh", resTag, expHigh[resTag], resHigh);
					compareWord("resLow", resTag, expLow[resTag], resLow);
					pending[resTag] = 1'b0;
				end
				testResults++;
			end
			if (reportTest) begin
				for (int t = 0; t < tagCount; t++) begin
					if (pending[t]) begin
						$display("tag %0d was never returned", t);
						countError();
					end
				end
				pending = '0;
				$display("test %0d (%s): %0d commands, %0d results, %0d errors",
					testId, testName(testId), testCmds, testResults, testErrors);
				totalCmds += testCmds;
				totalResults += testResults;
				testsRun++;
				testCmds = 0;
				testResults = 0;
				testErrors = 0;
			end
			if (reportFinal) begin
				$display("summary: %0d tests, %0d commands, %0d results, %0d errors",
					testsRun, totalCmds, totalResults, errorCount);
			end
		end
	end

endmodule

`default_nettype wire

// ==== aluTb.sv ====
/* environment side of both four-phase channels; tags count modulo 16
   the run stops at a cycle limit scaled from the command count */
`timescale 1ns/10ps
`default_nettype none

module aluTb;
	import aluPkg::*;

	localparam int tagWidth = 4;
	localparam logic [31:0] seed = 32'd90302;
	// core, MUL, DIV, mixed, back-pressure, undecoded
	localparam int cmdTotal = 51 + 16 + 14 + 30 + 16 + 4;
	localparam int cycleLimit = cmdTotal * 40 + 200;
	localparam logic [31:0] shiftAmt [4] = '{32'd0, 32'd31, 32'd32, 32'd45};
	localparam logic [4:0] undecoded [4] = '{5'b00000, 5'b01101, 5'b01110, 5'b11111};

	logic clk;
	logic rstN;
	logic cmdReq;
	logic cmdAck;
	aluOp_e cmdOp;
	logic [dataWidth-1:0] cmdA;
	logic [dataWidth-1:0] cmdB;
	logic [tagWidth-1:0] cmdTag;
	logic resReq;
	logic resAck;
	logic [tagWidth-1:0] resTag;
	logic [dataWidth-1:0] resHigh;
	logic [dataWidth-1:0] resLow;
	int testId;
	logic reportTest;
	logic reportFinal;
	int errorCount;
	// separate streams so the two driving processes never share state
	logic [31:0] stimState;
	logic [31:0] ackState;
	logic [tagWidth-1:0] nextTag;
	int cmdSent;
	int resTaken;
	int cycles;
	int ackDelayBits;

	aluSubsystem #(.tagWidth(tagWidth)) uut (
		.clk(clk), .rstN(rstN), .cmdReq(cmdReq), .cmdAck(cmdAck), .cmdOp(cmdOp),
		.cmdA(cmdA), .cmdB(cmdB), .cmdTag(cmdTag), .resReq(resReq), .resAck(resAck),
		.resTag(resTag), .resHigh(resHigh), .resLow(resLow)
	);

	aluChecker #(.tagWidth(tagWidth)) resultCheck (
		.clk(clk), .rstN(rstN), .cmdAck(cmdAck), .cmdOp(cmdOp), .cmdA(cmdA),
		.cmdB(cmdB), .cmdTag(cmdTag), .resReq(resReq), .resAck(resAck),
		.resTag(resTag), .resHigh(resHigh), .resLow(resLow), .testId(testId),
		.reportTest(reportTest), .reportFinal(reportFinal), .errorCount(errorCount)
	);

	// right-shift Galois LFSR, taps 32 22 2 1
	function automatic logic [31:0] lfsrStep(input logic [31:0] s);
		if (s[0]) begin
			return (s >> 1) ^ 32'h8020_0003;
		end
		return s >> 1;
	endfunction

	// one step per bit taken, the bit shifted out is the output
	function automatic logic [31:0] stimBits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[30:0], stimState[0]};
			stimState = lfsrStep(stimState);
		end
		return v;
	endfunction

	function automatic logic [31:0] ackBits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[30:0], ackState[0]};
			ackState = lfsrStep(ackState);
		end
		return v;
	endfunction

	// 0 to 11 are core opcodes, 12 and 13 the iterative units
	function automatic aluOp_e opFromIndex(input int idx);
		case (idx)
			0: return opAdd;
			1: return opSub;
			2: return opShr;
			3: return opShra;
			4: return opShl;
			5: return opRor;
			6: return opRol;
			7: return opAnd;
			8: return opOr;
			9: return opIncPc;
			10: return opNeg;
			11: return opNot;
			12: return opMul;
			default: return opDiv;
		endcase
	endfunction

	// small shift amounts so both sides of 32 get hit
	function automatic logic [31:0] operandB(input aluOp_e op);
		case (op)
			opShr, opShra, opShl, opRor, opRol: return stimBits(6);
			default: return stimBits(32);
		endcase
	endfunction

	// called at edge plus 1 ns, returns there once cmdAck has dropped
	task automatic sendCmd(input aluOp_e op, input logic [31:0] x, input logic [31:0] y);
		cmdOp = op;
		cmdA = x;
		cmdB = y;
		cmdTag = nextTag;
		cmdReq = 1'b1;
		do begin
			@(posedge clk);
			#1;
		end while (!cmdAck);
		cmdReq = 1'b0;
		nextTag++;
		cmdSent++;
		do begin
			@(posedge clk);
			#1;
		end while (cmdAck);
	endtask

	task automatic sendRandom(input int opRange);
		aluOp_e op;
		logic [31:0] x;
		logic [31:0] y;
		op = opFromIndex(int'(stimBits(4)) % opRange);
		x = stimBits(32);
		y = operandB(op);
		sendCmd(op, x, y);
	endtask

	// drain all results, then let the checker close the test
	task automatic finishTest(input int id);
		while (resTaken != cmdSent) begin
			@(posedge clk);
			#1;
		end
		testId = id;
		reportTest = 1'b1;
		@(posedge clk);
		#1;
		reportTest = 1'b0;
	endtask

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// result side, resAck after a random number of cycles
	initial begin
		int delay;
		forever begin
			@(posedge clk);
			#1;
			if (rstN && resReq) begin
				delay = int'(ackBits(ackDelayBits));
				repeat (delay) begin
					@(posedge clk);
					#1;
				end
				resAck = 1'b1;
				while (resReq) begin
					@(posedge clk);
					#1;
				end
				resAck = 1'b0;
				resTaken++;
			end
		end
	end

	initial begin
		cycles = 0;
		while (cycles < cycleLimit) begin
			@(posedge clk);
			cycles++;
		end
		$display("timeout after %0d cycles with %0d of %0d results returned",
			cycles, resTaken, cmdSent);
		$display("sim failed");
		$finish;
	end

	initial begin
		logic [31:0] x;
		logic [31:0] y;
		rstN = 1'b0;
		cmdReq = 1'b0;
		cmdOp = opAdd;
		cmdA = '0;
		cmdB = '0;
		cmdTag = '0;
		resAck = 1'b0;
		testId = 0;
		reportTest = 1'b0;
		reportFinal = 1'b0;
		stimState = seed;
		ackState = ~seed;
		nextTag = '0;
		cmdSent = 0;
		resTaken = 0;
		ackDelayBits = 3;
		repeat (2) @(posedge clk);
		#1;
		rstN = 1'b1;
		@(posedge clk);
		#1;

		// single-cycle opcodes, then shift amounts around the word size
		repeat (30) sendRandom(12);
		for (int i = 0; i < 4; i++) begin
			x = stimBits(32);
			sendCmd(opShr, x, shiftAmt[i]);
			sendCmd(opShl, x, shiftAmt[i]);
			sendCmd(opRor, x, shiftAmt[i]);
			sendCmd(opRol, x, shiftAmt[i]);
			// negative A so SHRA has to fill with ones
			sendCmd(opShra, x | 32'h8000_0000, shiftAmt[i]);
		end
		sendCmd(opShra, 32'hF000_0000, 32'h8000_0000);
		finishTest(1);

		repeat (12) begin
			x = stimBits(32);
			y = stimBits(32);
			sendCmd(opMul, x, y);
		end
		// most negative value against the corners
		sendCmd(opMul, 32'h8000_0000, 32'h8000_0000);
		sendCmd(opMul, 32'h8000_0000, 32'hFFFF_FFFF);
		sendCmd(opMul, 32'h8000_0000, 32'h7FFF_FFFF);
		sendCmd(opMul, 32'hFFFF_FFFF, 32'hFFFF_FFFF);
		finishTest(2);

		repeat (10) begin
			x = stimBits(32);
			y = stimBits(32);
			// random right shift gives small divisors too
			y = y >> stimBits(5);
			sendCmd(opDiv, x, y);
		end
		sendCmd(opDiv, 32'h1234_5678, 32'h0);
		sendCmd(opDiv, 32'h0, 32'h0);
		sendCmd(opDiv, 32'hFFFF_FFFF, 32'h1);
		sendCmd(opDiv, 32'h5, 32'h7);
		finishTest(3);

		// back-to-back commands over all three units
		repeat (30) sendRandom(14);
		finishTest(4);

		ackDelayBits = 5;
		repeat (16) sendRandom(14);
		finishTest(5);
		ackDelayBits = 3;

		for (int i = 0; i < 4; i++) begin
			x = stimBits(32);
			y = stimBits(32);
			sendCmd(aluOp_e'(undecoded[i]), x, y);
		end
		finishTest(6);

		reportFinal = 1'b1;
		@(posedge clk);
		#1;
		reportFinal = 1'b0;
		@(posedge clk);
		#1;
		if (errorCount == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== project.f ====
aluPkg.sv
opDispatch.sv
aluCore.sv
boothMultiplier.sv
nonRestoringDivider.sv
resultArbiter.sv
aluSubsystem.sv
aluChecker.sv
aluTb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS ?= --binary --timing --assert -Wno-fatal
TOP ?= aluTb
FILELIST ?= project.f
BUILD_DIR ?= obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "sim passed"

clean:
	rm -rf $(BUILD_DIR)
